// ==== verilog/vdec_cfg.svh ====
// sizing macros for the vector decoder: word widths, queue depth, element group
`ifndef VDEC_CFG_SVH
`define VDEC_CFG_SVH

// scalar operand and instruction width
`define VDEC_XLEN 32

// queue entries, also the credits issue starts with
`define VDEC_QDEPTH 4

// vector register file address width
`define VDEC_VREG_AW 5

// width of the vl input
`define VDEC_VL_W 5

// elements handled per exec cycle
`define VDEC_GROUP 4

`endif

// ==== verilog/vdec_pkg.sv ====
// vdec_pkg: opcode, funct3, funct6, PE control and sequencer state enums
package vdec_pkg;

    typedef enum logic [6:0]
    {
        V_MAJOR_OP_V = 7'b1010111
    } major_opcode_e;

    typedef enum logic [2:0]
    {
        V_OPIVV = 3'b000,
        V_OPMVV = 3'b010,
        V_OPIVI = 3'b011,
        V_OPIVX = 3'b100,
        V_OPMVX = 3'b110,
        V_OPCFG = 3'b111
    } funct3_e;

    // arithmetic group kept by the decoder
    typedef enum logic [5:0]
    {
        F6_VADD  = 6'b000000,
        F6_VSUB  = 6'b000010,
        F6_VMIN  = 6'b000101,
        F6_VMAX  = 6'b000111,
        F6_VAND  = 6'b001001,
        F6_VOR   = 6'b001010,
        F6_VXOR  = 6'b001011,
        F6_VMV   = 6'b010111,
        F6_VSADD = 6'b100001
    } funct6_e;

    typedef enum logic [2:0]
    {
        PE_OP_ADD,
        PE_OP_SUB,
        PE_OP_AND,
        PE_OP_OR,
        PE_OP_XOR
    } pe_op_e;

    typedef enum logic [1:0]
    {
        PE_OPERAND_VS1,
        PE_OPERAND_SCALAR,
        PE_OPERAND_IMMEDIATE,
        PE_OPERAND_RIPPLE
    } pe_operand_e;

    typedef enum logic [1:0]
    {
        PE_OUT_RESULT,
        PE_OUT_PASS_MIN,
        PE_OUT_PASS_MAX
    } pe_out_mode_e;

    typedef enum logic
    {
        PE_SAT_NONE,
        PE_SAT
    } pe_sat_e;

    typedef enum logic
    {
        SEQ_IDLE,
        SEQ_EXEC
    } seq_state_e;

endpackage

// ==== verilog/vdec_issue.sv ====
// vdec_issue: req/gnt acceptance, credit counter and registered queue push
`timescale 1ns/100ps
`include "vdec_cfg.svh"

module vdec_issue (
    input  logic                  clk,
    input  logic                  n_reset,
    input  logic                  apu_req_i,
    input  logic [`VDEC_XLEN-1:0] instr_i,
    input  logic [`VDEC_XLEN-1:0] scalar_i,
    input  logic                  credit_return_i,
    output logic                  apu_gnt_o,
    output logic                  push_o,
    output logic [`VDEC_XLEN-1:0] push_instr_o,
    output logic [`VDEC_XLEN-1:0] push_scalar_o
);

    localparam int CRED_W = $clog2(`VDEC_QDEPTH + 1);

    logic [CRED_W-1:0] credits;
    logic              accept;

    // grant only while a queue slot is guaranteed
    assign apu_gnt_o = (credits != '0);
    assign accept = apu_req_i & apu_gnt_o;

    always_ff @(posedge clk or negedge n_reset)
    begin
        if (!n_reset)
        begin
            credits <= CRED_W'(`VDEC_QDEPTH);
            push_o <= 1'b0;
        end
        else
        begin
            push_o <= accept;
            // take and return in one cycle cancel out
            case ({accept, credit_return_i})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // word captured on the accept edge, pushed the cycle after
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            push_instr_o <= instr_i;
            push_scalar_o <= scalar_i;
        end
    end

endmodule

// ==== verilog/vdec_queue.sv ====
// vdec_queue: circular instruction FIFO with one registered credit per pop
`timescale 1ns/100ps
`include "vdec_cfg.svh"

module vdec_queue (
    input  logic                  clk,
    input  logic                  n_reset,
    input  logic                  push_i,
    input  logic [`VDEC_XLEN-1:0] push_instr_i,
    input  logic [`VDEC_XLEN-1:0] push_scalar_i,
    input  logic                  pop_i,
    output logic                  q_valid_o,
    output logic [`VDEC_XLEN-1:0] q_instr_o,
    output logic [`VDEC_XLEN-1:0] q_scalar_o,
    output logic                  credit_return_o
);

    localparam int PTR_W = $clog2(`VDEC_QDEPTH);
    localparam int CNT_W = $clog2(`VDEC_QDEPTH + 1);

    // entry is {instruction, scalar}
    logic [2*`VDEC_XLEN-1:0] mem [`VDEC_QDEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`VDEC_QDEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign q_valid_o = (count != '0);
    assign {q_instr_o, q_scalar_o} = mem[rd_ptr];

    always_ff @(posedge clk or negedge n_reset)
    begin
        if (!n_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit_return_o <= 1'b0;
        end
        else
        begin
            credit_return_o <= pop_i;
            if (push_i)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop_i)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push_i, pop_i})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // no full check, issue holds a credit for every push
    always_ff @(posedge clk)
    begin
        if (push_i)
            mem[wr_ptr] <= {push_instr_i, push_scalar_i};
    end

endmodule

// ==== verilog/vdec_op_decode.sv ====
// vdec_op_decode: instruction fields to PE controls, vsetvli flags and illegal
`timescale 1ns/100ps
`include "vdec_cfg.svh"

module vdec_op_decode (
    input  logic [`VDEC_XLEN-1:0] instr_i,
    output vdec_pkg::pe_op_e      pe_op_o,
    output vdec_pkg::pe_operand_e operand_select_o,
    output vdec_pkg::pe_out_mode_e output_mode_o,
    output vdec_pkg::pe_sat_e     saturate_o,
    output logic                  vec_reg_write_o,
    output logic                  multi_cycle_o,
    output logic                  fix_vd_o,
    output logic                  csr_write_o,
    output logic                  preserve_vl_o,
    output logic                  set_vl_max_o,
    output logic                  illegal_o
);

    import vdec_pkg::*;

    funct3_e    funct3;
    funct6_e    funct6;
    logic [4:0] rs1;
    logic [4:0] rd;
    logic       reduce;

    assign funct3 = funct3_e'(instr_i[14:12]);
    assign funct6 = funct6_e'(instr_i[31:26]);
    assign rs1 = instr_i[19:15];
    assign rd = instr_i[11:7];
    // OPMVV form of vadd/vmax is the reduction
    assign reduce = (funct3 == V_OPMVV);

    always_comb
    begin
        pe_op_o = PE_OP_ADD;
        output_mode_o = PE_OUT_RESULT;
        saturate_o = PE_SAT_NONE;
        vec_reg_write_o = 1'b0;
        multi_cycle_o = 1'b0;
        fix_vd_o = 1'b0;
        csr_write_o = 1'b0;
        preserve_vl_o = 1'b0;
        set_vl_max_o = 1'b0;
        illegal_o = 1'b0;

        // second operand follows the funct3 form
        case (funct3)
            V_OPIVX, V_OPMVX: operand_select_o = PE_OPERAND_SCALAR;
            V_OPIVI: operand_select_o = PE_OPERAND_IMMEDIATE;
            default: operand_select_o = PE_OPERAND_VS1;
        endcase

        if (instr_i[6:0] != V_MAJOR_OP_V)
            illegal_o = 1'b1;
        else if (funct3 == V_OPCFG)
        begin
            // vsetvli
            csr_write_o = 1'b1;
            if (rs1 == '0)
            begin
                if (rd == '0)
                    preserve_vl_o = 1'b1;
                else
                    set_vl_max_o = 1'b1;
            end
        end
        else
        begin
            vec_reg_write_o = 1'b1;
            multi_cycle_o = 1'b1;
            case (funct6)
                F6_VADD, F6_VMAX:
                begin
                    if (funct6 == F6_VMAX)
                    begin
                        pe_op_o = PE_OP_SUB;
                        output_mode_o = PE_OUT_PASS_MAX;
                    end
                    if (reduce)
                    begin
                        operand_select_o = PE_OPERAND_RIPPLE;
                        fix_vd_o = 1'b1;
                    end
                end
                F6_VSUB: pe_op_o = PE_OP_SUB;
                F6_VMIN:
                begin
                    pe_op_o = PE_OP_SUB;
                    output_mode_o = PE_OUT_PASS_MIN;
                end
                F6_VAND: pe_op_o = PE_OP_AND;
                F6_VOR: pe_op_o = PE_OP_OR;
                F6_VXOR: pe_op_o = PE_OP_XOR;
                // vmv.v passes the operand straight through the adder
                F6_VMV: pe_op_o = PE_OP_ADD;
                F6_VSADD: saturate_o = PE_SAT;
                default:
                begin
                    vec_reg_write_o = 1'b0;
                    multi_cycle_o = 1'b0;
                    illegal_o = 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== verilog/vdec_sequencer.sv ====
// vdec_sequencer: pops queued words, steps element groups, addresses and write counts
`timescale 1ns/100ps
`include "vdec_cfg.svh"

module vdec_sequencer (
    input  logic                     clk,
    input  logic                     n_reset,
    input  logic                     q_valid_i,
    input  logic [`VDEC_XLEN-1:0]    q_instr_i,
    input  logic [`VDEC_XLEN-1:0]    q_scalar_i,
    input  logic                     stall_i,
    input  logic [`VDEC_VL_W-1:0]    vl_i,
    input  logic [1:0]               vsew_i,
    output logic                     pop_o,
    output logic                     busy_o,
    output logic                     rvalid_o,
    output logic [`VDEC_VREG_AW-1:0] vs1_addr_o,
    output logic [`VDEC_VREG_AW-1:0] vs2_addr_o,
    output logic [`VDEC_VREG_AW-1:0] vd_addr_o,
    output logic [10:0]              immediate_o,
    output logic [`VDEC_XLEN-1:0]    scalar_o,
    output logic [1:0]               elements_to_write_o,
    output vdec_pkg::pe_op_e         pe_op_o,
    output vdec_pkg::pe_operand_e    operand_select_o,
    output vdec_pkg::pe_out_mode_e   output_mode_o,
    output vdec_pkg::pe_sat_e        saturate_o,
    output logic                     vec_reg_write_o,
    output logic                     multi_cycle_o,
    output logic                     fix_vd_o,
    output logic                     csr_write_o,
    output logic                     preserve_vl_o,
    output logic                     set_vl_max_o,
    output logic                     illegal_o
);

    import vdec_pkg::*;

    localparam int GROUP_SHIFT = $clog2(`VDEC_GROUP);
    localparam int CNT_W = `VDEC_VL_W - GROUP_SHIFT;
    localparam int PAD_W = `VDEC_VREG_AW - CNT_W;

    seq_state_e                state;
    logic [CNT_W-1:0]          cycle_cnt;
    logic [CNT_W-1:0]          max_cnt;
    logic [`VDEC_VL_W-1:0]     vl_m1;
    logic                      last_cycle;
    logic [`VDEC_VREG_AW-1:0]  step;
    logic [`VDEC_XLEN-1:0]     instr_q;
    logic [`VDEC_XLEN-1:0]     scalar_q;

    pe_op_e       dec_pe_op;
    pe_operand_e  dec_operand;
    pe_out_mode_e dec_out_mode;
    pe_sat_e      dec_sat;
    logic         dec_vec_write;
    logic         dec_multi_cycle;
    logic         dec_fix_vd;
    logic         dec_csr_write;
    logic         dec_preserve_vl;
    logic         dec_set_vl_max;
    logic         dec_illegal;

    vdec_op_decode u_op_decode (
        .instr_i          (instr_q),
        .pe_op_o          (dec_pe_op),
        .operand_select_o (dec_operand),
        .output_mode_o    (dec_out_mode),
        .saturate_o       (dec_sat),
        .vec_reg_write_o  (dec_vec_write),
        .multi_cycle_o    (dec_multi_cycle),
        .fix_vd_o         (dec_fix_vd),
        .csr_write_o      (dec_csr_write),
        .preserve_vl_o    (dec_preserve_vl),
        .set_vl_max_o     (dec_set_vl_max),
        .illegal_o        (dec_illegal)
    );

    assign busy_o = (state == SEQ_EXEC);
    assign pop_o = (state == SEQ_IDLE) & q_valid_i;

    // one group per cycle, single cycle for vsetvli and illegal words
    assign vl_m1 = vl_i - 1'b1;
    assign max_cnt = dec_multi_cycle ? vl_m1[`VDEC_VL_W-1:GROUP_SHIFT] : '0;
    assign last_cycle = (cycle_cnt == max_cnt);
    assign rvalid_o = busy_o & ~stall_i & last_cycle;

    always_ff @(posedge clk or negedge n_reset)
    begin
        if (!n_reset)
        begin
            state <= SEQ_IDLE;
            cycle_cnt <= '0;
        end
        else
        begin
            case (state)
                SEQ_IDLE:
                begin
                    cycle_cnt <= '0;
                    if (q_valid_i)
                        state <= SEQ_EXEC;
                end
                default:
                begin
                    if (!stall_i)
                    begin
                        if (last_cycle)
                        begin
                            state <= SEQ_IDLE;
                            cycle_cnt <= '0;
                        end
                        else
                            cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop_o)
        begin
            instr_q <= q_instr_i;
            scalar_q <= q_scalar_i;
        end
    end

    // registers advance by two per group at SEW 16
    assign step = (vsew_i == 2'd1) ? {{(PAD_W - 1){1'b0}}, cycle_cnt, 1'b0}
                                   : {{PAD_W{1'b0}}, cycle_cnt};
    assign vs1_addr_o = instr_q[19:15] + step;
    assign vs2_addr_o = instr_q[24:20] + step;
    // reductions accumulate into a single vd
    assign vd_addr_o = dec_fix_vd ? instr_q[11:7] : instr_q[11:7] + step;

    assign immediate_o = (instr_q[14:12] == V_OPCFG) ? instr_q[30:20]
                                                     : {6'b0, instr_q[19:15]};
    assign scalar_o = scalar_q;

    always_comb
    begin
        elements_to_write_o = 2'd0;
        if (busy_o && dec_multi_cycle && last_cycle)
        begin
            if (dec_operand == PE_OPERAND_RIPPLE)
                elements_to_write_o = 2'd1;
            else
                elements_to_write_o = vl_i[GROUP_SHIFT-1:0];
        end
    end

    // controls held at their idle values outside exec
    assign pe_op_o = busy_o ? dec_pe_op : PE_OP_ADD;
    assign operand_select_o = busy_o ? dec_operand : PE_OPERAND_VS1;
    assign output_mode_o = busy_o ? dec_out_mode : PE_OUT_RESULT;
    assign saturate_o = busy_o ? dec_sat : PE_SAT_NONE;
    assign vec_reg_write_o = busy_o & dec_vec_write;
    assign multi_cycle_o = busy_o & dec_multi_cycle;
    assign fix_vd_o = busy_o & dec_fix_vd;
    assign csr_write_o = busy_o & dec_csr_write;
    assign preserve_vl_o = busy_o & dec_preserve_vl;
    assign set_vl_max_o = busy_o & dec_set_vl_max;
    assign illegal_o = busy_o & dec_illegal;

endmodule

// ==== verilog/vector_decoder.sv ====
// vector_decoder: issue stage, instruction queue and sequencer
`timescale 1ns/100ps
`include "vdec_cfg.svh"

module vector_decoder (
    input  logic                     clk,
    input  logic                     n_reset,
    input  logic                     apu_req_i,
    input  logic [`VDEC_XLEN-1:0]    instr_i,
    input  logic [`VDEC_XLEN-1:0]    scalar_i,
    input  logic                     stall_i,
    input  logic [`VDEC_VL_W-1:0]    vl_i,
    input  logic [1:0]               vsew_i,
    output logic                     apu_gnt_o,
    output logic                     busy_o,
    output logic                     rvalid_o,
    output logic [`VDEC_VREG_AW-1:0] vs1_addr_o,
    output logic [`VDEC_VREG_AW-1:0] vs2_addr_o,
    output logic [`VDEC_VREG_AW-1:0] vd_addr_o,
    output logic [10:0]              immediate_o,
    output logic [`VDEC_XLEN-1:0]    scalar_o,
    output logic [1:0]               elements_to_write_o,
    output vdec_pkg::pe_op_e         pe_op_o,
    output vdec_pkg::pe_operand_e    operand_select_o,
    output vdec_pkg::pe_out_mode_e   output_mode_o,
    output vdec_pkg::pe_sat_e        saturate_o,
    output logic                     vec_reg_write_o,
    output logic                     multi_cycle_o,
    output logic                     fix_vd_o,
    output logic                     csr_write_o,
    output logic                     preserve_vl_o,
    output logic                     set_vl_max_o,
    output logic                     illegal_o
);

    logic                  push;
    logic [`VDEC_XLEN-1:0] push_instr;
    logic [`VDEC_XLEN-1:0] push_scalar;
    logic                  credit_return;
    logic                  q_valid;
    logic [`VDEC_XLEN-1:0] q_instr;
    logic [`VDEC_XLEN-1:0] q_scalar;
    logic                  pop;

    vdec_issue u_issue (
        .clk             (clk),
        .n_reset         (n_reset),
        .apu_req_i       (apu_req_i),
        .instr_i         (instr_i),
        .scalar_i        (scalar_i),
        .credit_return_i (credit_return),
        .apu_gnt_o       (apu_gnt_o),
        .push_o          (push),
        .push_instr_o    (push_instr),
        .push_scalar_o   (push_scalar)
    );

    vdec_queue u_queue (
        .clk             (clk),
        .n_reset         (n_reset),
        .push_i          (push),
        .push_instr_i    (push_instr),
        .push_scalar_i   (push_scalar),
        .pop_i           (pop),
        .q_valid_o       (q_valid),
        .q_instr_o       (q_instr),
        .q_scalar_o      (q_scalar),
        .credit_return_o (credit_return)
    );

    vdec_sequencer u_sequencer (
        .clk                 (clk),
        .n_reset             (n_reset),
        .q_valid_i           (q_valid),
        .q_instr_i           (q_instr),
        .q_scalar_i          (q_scalar),
        .stall_i             (stall_i),
        .vl_i                (vl_i),
        .vsew_i              (vsew_i),
        .pop_o               (pop),
        .busy_o              (busy_o),
        .rvalid_o            (rvalid_o),
        .vs1_addr_o          (vs1_addr_o),
        .vs2_addr_o          (vs2_addr_o),
        .vd_addr_o           (vd_addr_o),
        .immediate_o         (immediate_o),
        .scalar_o            (scalar_o),
        .elements_to_write_o (elements_to_write_o),
        .pe_op_o             (pe_op_o),
        .operand_select_o    (operand_select_o),
        .output_mode_o       (output_mode_o),
        .saturate_o          (saturate_o),
        .vec_reg_write_o     (vec_reg_write_o),
        .multi_cycle_o       (multi_cycle_o),
        .fix_vd_o            (fix_vd_o),
        .csr_write_o         (csr_write_o),
        .preserve_vl_o       (preserve_vl_o),
        .set_vl_max_o        (set_vl_max_o),
        .illegal_o           (illegal_o)
    );

endmodule

// ==== verif/vector_decoder_checker.sv ====
// vector_decoder_checker: concurrent assertions on grant, busy, rvalid and write enable
`timescale 1ns/100ps

module vector_decoder_checker (
    input logic clk,
    input logic n_reset,
    input logic stall_i,
    input logic apu_gnt_o,
    input logic busy_o,
    input logic rvalid_o,
    input logic vec_reg_write_o
);

    // exec ends only through the rvalid cycle
    a_exec_ends_with_rvalid: assert property (@(posedge clk) disable iff (!n_reset)
        busy_o && !rvalid_o |=> busy_o)
        else $error("busy_o dropped without rvalid_o");

    // decoded word is held for the whole instruction
    a_write_steady_in_exec: assert property (@(posedge clk) disable iff (!n_reset)
        busy_o && !rvalid_o |=> $stable(vec_reg_write_o))
        else $error("vec_reg_write_o changed inside one instruction");

    // sequencer returns to idle after the last cycle
    a_idle_after_rvalid: assert property (@(posedge clk) disable iff (!n_reset)
        rvalid_o |=> !busy_o)
        else $error("busy_o still high after rvalid_o");

    a_stall_holds_busy: assert property (@(posedge clk) disable iff (!n_reset)
        busy_o && stall_i |=> busy_o)
        else $error("busy_o dropped during a stall");

    // full credit count right after reset
    a_gnt_after_reset: assert property (@(posedge clk)
        $rose(n_reset) |-> apu_gnt_o)
        else $error("apu_gnt_o low after reset");

endmodule

// ==== verif/vector_decoder_tb.sv ====
// vector_decoder_tb: case-file driven decode, sequencing and flow control test
`timescale 1ns/100ps
`include "vdec_cfg.svh"

module vector_decoder_tb;

    logic clk;
    logic n_reset;
    logic apu_req_i;
    logic [31:0] instr_i;
    logic [31:0] scalar_i;
    logic stall_i;
    logic [`VDEC_VL_W-1:0] vl_i;
    logic [1:0] vsew_i;
    logic apu_gnt_o;
    logic busy_o;
    logic rvalid_o;
    logic [4:0] vs1_addr_o;
    logic [4:0] vs2_addr_o;
    logic [4:0] vd_addr_o;
    logic [10:0] immediate_o;
    logic [31:0] scalar_o;
    logic [1:0] elements_to_write_o;
    vdec_pkg::pe_op_e pe_op_o;
    vdec_pkg::pe_operand_e operand_select_o;
    vdec_pkg::pe_out_mode_e output_mode_o;
    vdec_pkg::pe_sat_e saturate_o;
    logic vec_reg_write_o;
    logic multi_cycle_o;
    logic fix_vd_o;
    logic csr_write_o;
    logic preserve_vl_o;
    logic set_vl_max_o;
    logic illegal_o;

    string c_name[64];
    logic [31:0] c_instr[64];
    logic [31:0] c_scalar[64];
    int c_vl[64];
    int c_sew[64];
    int c_exp[64][9];
    int n_cases;
    int cycles;
    int limit;
    integer seed;

    vector_decoder u_vector_decoder (.*);

    bind vector_decoder vector_decoder_checker u_checker (.*);

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > limit)
        begin
            $display("timeout: run took more than %0d cycles", limit);
            $display("ERRORS FOUND");
            $fatal(1, "simulation stopped");
        end
    end

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("mismatch %s %s expected %0h actual %0h", test, field, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic read_cases;
        int fd;
        int r;
        string line;
        fd = $fopen("verif/vector_decoder_cases.txt", "r");
        if (fd == 0)
            fail_plain("could not open the case file");
        n_cases = 0;
        while (!$feof(fd) && n_cases < 64)
        begin
            line = "";
            r = $fgets(line, fd);
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            r = $sscanf(line, "%s %h %h %d %d %d %d %d %d %d %d %d %d %d",
                        c_name[n_cases], c_instr[n_cases], c_scalar[n_cases],
                        c_vl[n_cases], c_sew[n_cases], c_exp[n_cases][0],
                        c_exp[n_cases][1], c_exp[n_cases][2], c_exp[n_cases][3],
                        c_exp[n_cases][4], c_exp[n_cases][5], c_exp[n_cases][6],
                        c_exp[n_cases][7], c_exp[n_cases][8]);
            if (r != 14)
                fail_plain("a line of the case file has the wrong number of fields");
            n_cases++;
        end
        $fclose(fd);
        if (n_cases == 0)
            fail_plain("the case file holds no cases");
    endtask

    // request held from a falling edge until the grant is seen
    task automatic issue_word(input logic [31:0] instr, input logic [31:0] scalar);
        @(negedge clk);
        apu_req_i = 1'b1;
        instr_i = instr;
        scalar_i = scalar;
        #1;
        while (!apu_gnt_o)
        begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        apu_req_i = 1'b0;
    endtask

    task automatic check_idle(input string test);
        check_value(test, "idle vec_reg_write_o", 0, 32'(vec_reg_write_o));
        check_value(test, "idle csr_write_o", 0, 32'(csr_write_o));
        check_value(test, "idle illegal_o", 0, 32'(illegal_o));
        check_value(test, "idle pe_op_o", 0, 32'(pe_op_o));
        check_value(test, "idle multi_cycle_o", 0, 32'(multi_cycle_o));
        check_value(test, "idle fix_vd_o", 0, 32'(fix_vd_o));
        check_value(test, "idle rvalid_o", 0, 32'(rvalid_o));
    endtask

    task automatic run_case(input int i);
        int k;
        int n;
        int ewr;
        bit done;
        logic red;
        logic [4:0] step;
        logic [10:0] imm;
        n = (c_exp[i][4] != 0) ? ((c_vl[i] - 1) >> 2) + 1 : 1;
        red = (c_exp[i][1] == 3);
        imm = (c_instr[i][14:12] == 3'b111) ? c_instr[i][30:20] : {6'b0, c_instr[i][19:15]};
        // previous instruction has left exec by this falling edge
        @(negedge clk);
        vl_i = 5'(c_vl[i]);
        vsew_i = 2'(c_sew[i]);
        issue_word(c_instr[i], c_scalar[i]);
        k = 0;
        done = 0;
        while (!done)
        begin
            @(negedge clk);
            stall_i = (($random(seed) & 3) == 0);
            #25;
            if (!busy_o)
            begin
                if (k > 0)
                    check_value(c_name[i], "busy_o before rvalid", 1, 0);
                check_idle(c_name[i]);
            end
            else
            begin
                check_value(c_name[i], "pe_op", 32'(c_exp[i][0]), 32'(pe_op_o));
                check_value(c_name[i], "operand_select", 32'(c_exp[i][1]),
                            32'(operand_select_o));
                check_value(c_name[i], "output_mode", 32'(c_exp[i][2]), 32'(output_mode_o));
                check_value(c_name[i], "saturate", 32'(c_exp[i][3]), 32'(saturate_o));
                check_value(c_name[i], "vec_reg_write", 32'(c_exp[i][4]),
                            32'(vec_reg_write_o));
                check_value(c_name[i], "csr_write", 32'(c_exp[i][5]), 32'(csr_write_o));
                check_value(c_name[i], "preserve_vl", 32'(c_exp[i][6]), 32'(preserve_vl_o));
                check_value(c_name[i], "set_vl_max", 32'(c_exp[i][7]), 32'(set_vl_max_o));
                check_value(c_name[i], "illegal", 32'(c_exp[i][8]), 32'(illegal_o));
                // vector-writing ops run over element groups
                check_value(c_name[i], "multi_cycle", 32'(c_exp[i][4]), 32'(multi_cycle_o));
                check_value(c_name[i], "fix_vd", 32'(red), 32'(fix_vd_o));
                check_value(c_name[i], "immediate", 32'(imm), 32'(immediate_o));
                check_value(c_name[i], "scalar", c_scalar[i], scalar_o);
                // SEW 16 steps two registers per group
                step = (c_sew[i] == 1) ? 5'(2 * k) : 5'(k);
                check_value(c_name[i], "vs1_addr", 32'(c_instr[i][19:15] + step),
                            32'(vs1_addr_o));
                check_value(c_name[i], "vs2_addr", 32'(c_instr[i][24:20] + step),
                            32'(vs2_addr_o));
                check_value(c_name[i], "vd_addr",
                            red ? 32'(c_instr[i][11:7]) : 32'(c_instr[i][11:7] + step),
                            32'(vd_addr_o));
                ewr = 0;
                if (k == n - 1 && c_exp[i][4] != 0)
                    ewr = red ? 1 : c_vl[i] % 4;
                check_value(c_name[i], "elements_to_write", 32'(ewr),
                            32'(elements_to_write_o));
                check_value(c_name[i], "rvalid",
                            32'(!stall_i && k == n - 1), 32'(rvalid_o));
                if (!stall_i)
                begin
                    if (k == n - 1)
                        done = 1;
                    k++;
                end
            end
        end
    endtask

    // burst of vsetvli words under a held stall, then drained in order
    task automatic check_flow;
        int accepted;
        int low;
        int j;
        logic [31:0] w_instr[8];
        logic [31:0] w_scalar[8];
        for (j = 0; j < 8; j++)
        begin
            w_instr[j] = {1'b0, 11'(j * 3 + 1), 5'd1, 3'b111, 5'd2, 7'h57};
            w_scalar[j] = $random(seed);
        end
        @(negedge clk);
        vl_i = 5'd8;
        vsew_i = 2'd0;
        stall_i = 1'b1;
        accepted = 0;
        low = 0;
        while (low < 8 && accepted < 8)
        begin
            apu_req_i = 1'b1;
            instr_i = w_instr[accepted];
            scalar_i = w_scalar[accepted];
            #1;
            if (apu_gnt_o)
            begin
                accepted++;
                low = 0;
            end
            else
                low++;
            @(negedge clk);
        end
        apu_req_i = 1'b0;
        check_value("flow_control", "accepted", `VDEC_QDEPTH + 1, 32'(accepted));
        stall_i = 1'b0;
        for (j = 0; j < accepted; j++)
        begin
            #25;
            while (!rvalid_o)
            begin
                @(negedge clk);
                #25;
            end
            check_value("flow_control", "order immediate", 32'(w_instr[j][30:20]),
                        32'(immediate_o));
            check_value("flow_control", "order scalar", w_scalar[j], scalar_o);
            @(negedge clk);
        end
        #25;
        while (!apu_gnt_o)
        begin
            @(negedge clk);
            #25;
        end
    endtask

    initial
    begin
        int i;
        seed = 32'h7529bd87;
        cycles = 0;
        limit = 100;
        clk = 1'b0;
        n_reset = 1'b0;
        apu_req_i = 1'b0;
        instr_i = '0;
        scalar_i = '0;
        stall_i = 1'b0;
        vl_i = '0;
        vsew_i = '0;
        read_cases();
        limit = n_cases * (`VDEC_GROUP + 2) * 4 + 100;
        repeat (10) @(posedge clk);
        @(negedge clk);
        n_reset = 1'b1;
        #25;
        check_value("reset", "apu_gnt_o", 1, 32'(apu_gnt_o));
        check_value("reset", "busy_o", 0, 32'(busy_o));
        check_idle("reset");
        for (i = 0; i < n_cases; i++)
            run_case(i);
        check_flow();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== vector_decoder.f ====
+incdir+verilog
verilog/vdec_pkg.sv
verilog/vdec_issue.sv
verilog/vdec_queue.sv
verilog/vdec_op_decode.sv
verilog/vdec_sequencer.sv
verilog/vector_decoder.sv
verif/vector_decoder_checker.sv
verif/vector_decoder_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= vector_decoder_tb
FLIST ?= vector_decoder.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/vector_decoder_cases.txt ====
# name instr(hex) scalar(hex) vl vsew | expected pe_op operand_select output_mode saturate
# vec_reg_write csr_write preserve_vl set_vl_max illegal (all decimal)
# fields: vs2=8 vs1/rs1=4 rd=16 unless the instruction says otherwise
vadd_vv    02820857 00000000 16 0 0 0 0 0 1 0 0 0 0
vadd_vx    02824857 00001234 7  0 0 1 0 0 1 0 0 0 0
vadd_vi    02823857 0000abcd 5  1 0 2 0 0 1 0 0 0 0
vredsum_vs 02822857 00000011 9  0 0 3 0 0 1 0 0 0 0
vsub_vv    0a820857 00000022 4  1 1 0 0 0 1 0 0 0 0
vmin_vv    16820857 00000033 3  0 1 0 1 0 1 0 0 0 0
vmax_vx    1e824857 deadbeef 13 0 1 1 2 0 1 0 0 0 0
vredmax_vs 1e822857 00000044 6  1 1 3 2 0 1 0 0 0 0
vand_vv    26820857 00000055 8  0 2 0 0 0 1 0 0 0 0
vor_vx     2a824857 12345678 1  0 3 1 0 0 1 0 0 0 0
vxor_vi    2e823857 00000066 11 1 4 2 0 0 1 0 0 0 0
vmv_vv     5e820857 00000077 2  0 0 0 0 0 1 0 0 0 0
vsadd_vv   86820857 00000088 15 0 0 0 0 1 1 0 0 0 0
vmax_vv    1e820857 00000099 16 1 1 0 2 0 1 0 0 0 0
vand_vx    26824857 cafef00d 12 1 2 1 0 0 1 0 0 0 0
vsetvli    0d027857 000000aa 10 0 0 0 0 0 0 1 0 0 0
vsetvli_pv 00807057 000000bb 10 0 0 0 0 0 0 1 1 0 0
vsetvli_mx 011072d7 000000cc 10 0 0 0 0 0 0 1 0 1 0
bad_opcode 02820833 000000dd 8  0 0 0 0 0 0 0 0 0 1
bad_funct6 fe820857 000000ee 8  0 0 0 0 0 0 0 0 0 1
